// ==== include/layer_params.svh ====
/*
 * Layer dimensions
 * Sizes of the fully connected layer and its MAC array
 */
`ifndef LAYER_PARAMS_SVH
`define LAYER_PARAMS_SVH

// Length of the input vector
`define LAYER_IN_LEN 8

// Number of outputs of the layer
`define LAYER_OUT_LEN 16

// MAC lanes working in parallel
`define LAYER_LANES 4

// Outputs handled by one lane, one per row
`define LAYER_ROWS (`LAYER_OUT_LEN / `LAYER_LANES)

// Width of samples, weights, biases and results
`define LAYER_DATA_W 16

`endif

// ==== rtl/layer_coef_pkg.sv ====
/*
 * Layer coefficients
 * Weight and bias tables of the four MAC lanes
 */
`include "layer_params.svh"

package layer_coef_pkg;

   // Lane weights, entry row * 8 + column
   localparam layer_pkg::data_t weight_table
      [0:`LAYER_LANES-1][0:`LAYER_IN_LEN*`LAYER_ROWS-1] = '{
      '{
         -16'sd38,  16'sd33,  16'sd109, 16'sd24,  -16'sd3,   -16'sd45,  -16'sd19,  16'sd48,
         16'sd103,  16'sd18,  16'sd82,  -16'sd28, 16'sd101,  -16'sd64,  -16'sd108, 16'sd3,
         -16'sd18,  16'sd107, 16'sd2,   -16'sd45, -16'sd85,  16'sd22,   16'sd86,   16'sd32,
         -16'sd1,   -16'sd105, 16'sd81, 16'sd42,  16'sd45,   16'sd39,   -16'sd54,  16'sd63
      },
      '{
         16'sd29,   -16'sd75, -16'sd24, 16'sd89,  -16'sd12,  -16'sd72,  16'sd114,  -16'sd15,
         -16'sd11,  -16'sd4,  -16'sd36, 16'sd105, 16'sd53,   -16'sd50,  -16'sd37,  16'sd72,
         -16'sd110, -16'sd77, 16'sd9,   16'sd71,  16'sd1,    16'sd100,  16'sd15,   -16'sd72,
         16'sd90,   16'sd84,  16'sd7,   -16'sd36, 16'sd56,   -16'sd106, 16'sd20,   16'sd22
      },
      '{
         -16'sd109, -16'sd24, 16'sd30,  16'sd68,  -16'sd123, -16'sd41,  16'sd119,  16'sd31,
         16'sd54,   16'sd121, 16'sd12,  16'sd60,  -16'sd48,  16'sd3,    -16'sd37,  16'sd78,
         16'sd93,   -16'sd101, 16'sd116, -16'sd83, 16'sd31,  -16'sd49,  16'sd124,  16'sd29,
         -16'sd78,  16'sd8,   16'sd67,  16'sd81,  16'sd87,   16'sd63,   -16'sd18,  -16'sd105
      },
      '{
         -16'sd2,   -16'sd5,  16'sd22,  -16'sd23, 16'sd96,   -16'sd58,  16'sd36,   -16'sd70,
         16'sd126,  16'sd113, -16'sd73, 16'sd94,  -16'sd73,  16'sd92,   -16'sd104, -16'sd98,
         -16'sd64,  -16'sd77, -16'sd4,  -16'sd9,  -16'sd113, 16'sd20,   16'sd21,   -16'sd3,
         16'sd115,  16'sd106, 16'sd14,  -16'sd126, -16'sd1,  -16'sd93,  16'sd0,    16'sd126
      }
   };

   // Lane biases, one per row
   localparam layer_pkg::data_t bias_table [0:`LAYER_LANES-1][0:`LAYER_ROWS-1] = '{
      '{-16'sd70, 16'sd120, 16'sd71,  -16'sd60},
      '{-16'sd47, 16'sd115, -16'sd83, 16'sd67},
      '{16'sd41,  16'sd38,  -16'sd81, -16'sd106},
      '{16'sd103, 16'sd83,  16'sd0,   -16'sd10}
   };

endpackage

// ==== rtl/layer_pkg.sv ====
/*
 * Layer types
 * Data words, address fields and sequencer states of the layer
 */
`include "layer_params.svh"

package layer_pkg;

   // Signed sample, weight, bias or result
   typedef logic signed [`LAYER_DATA_W-1:0] data_t;

   // Position in the input vector
   typedef logic [$clog2(`LAYER_IN_LEN)-1:0] vec_addr_t;

   // Entry of a lane weight table, row * IN_LEN + column
   typedef logic [$clog2(`LAYER_IN_LEN * `LAYER_ROWS)-1:0] weight_addr_t;

   typedef logic [$clog2(`LAYER_ROWS)-1:0] row_t;          // Row of a lane
   typedef logic [$clog2(`LAYER_OUT_LEN)-1:0] out_idx_t;   // Output number

   typedef enum logic [1:0] {
      SEQ_IDLE,      // Waiting for a new vector
      SEQ_LOAD,      // Taking in the input words
      SEQ_COMPUTE,   // Running the MAC lanes
      SEQ_STREAM     // Sending the results
   } seq_state_t;

endpackage

// ==== rtl/layer_sequencer.sv ====
/*
 * Layer sequencer
 * Moves the layer through load, compute and stream, and generates the
 * operand addresses and the delayed MAC strobes
 */
`include "layer_params.svh"

module layer_sequencer (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    s_valid,
   input  logic                    stream_done,
   output logic                    s_ready,
   output logic                    vec_wr_en,
   output logic                    acc_clear,
   output logic                    acc_en,
   output logic                    row_done,
   output logic                    results_ready,
   output layer_pkg::vec_addr_t    vec_addr,
   output layer_pkg::weight_addr_t weight_addr,
   output layer_pkg::row_t         bias_addr,
   output layer_pkg::row_t         row_idx
);
   import layer_pkg::*;

   seq_state_t state;
   seq_state_t next_state;
   vec_addr_t  load_cnt;      // Words taken in so far
   vec_addr_t  col;
   row_t       row;
   row_t       row_d1;
   logic       col_active;    // Low while the row bias is fetched
   logic       drain;         // All operands issued, pipeline still busy
   logic       load_last;
   logic       issue_clear;
   logic       issue_acc;
   logic       issue_last;
   logic       acc_last;
   logic       compute_last;

   assign s_ready      = (state == SEQ_LOAD);
   assign vec_wr_en    = s_ready & s_valid;
   assign load_last    = vec_wr_en && (load_cnt == vec_addr_t'(`LAYER_IN_LEN - 1));
   assign issue_clear  = (state == SEQ_COMPUTE) && !drain && !col_active;
   assign issue_acc    = (state == SEQ_COMPUTE) && !drain && col_active;
   assign issue_last   = issue_acc && (col == vec_addr_t'(`LAYER_IN_LEN - 1));
   assign compute_last = row_done && (row_idx == row_t'(`LAYER_ROWS - 1));

   assign vec_addr    = (state == SEQ_LOAD) ? load_cnt : col;
   assign weight_addr = {row, col};   // row * 8 + column
   assign bias_addr   = row;

   always_comb begin
      next_state = state;
      case (state)
         SEQ_IDLE:    if (s_valid) next_state = SEQ_LOAD;
         SEQ_LOAD:    if (load_last) next_state = SEQ_COMPUTE;
         SEQ_COMPUTE: if (compute_last) next_state = SEQ_STREAM;
         SEQ_STREAM:  if (stream_done) next_state = SEQ_IDLE;
         default:     next_state = SEQ_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset || state == SEQ_IDLE) begin
         load_cnt   <= '0;
         col        <= '0;
         row        <= '0;
         col_active <= 1'b0;
         drain      <= 1'b0;
      end else begin
         if (vec_wr_en)
            load_cnt <= load_cnt + 1'b1;
         if (issue_clear)
            col_active <= 1'b1;
         if (issue_acc)
            col <= col + 1'b1;
         if (issue_last) begin
            col        <= '0;
            col_active <= 1'b0;
            row        <= row + 1'b1;
            if (row == row_t'(`LAYER_ROWS - 1))
               drain <= 1'b1;   // Last row issued
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset)
         state <= SEQ_IDLE;
      else
         state <= next_state;
   end

   // Strobes trail the addresses by the one cycle read latency
   always_ff @(posedge clk) begin
      if (reset) begin
         acc_clear     <= 1'b0;
         acc_en        <= 1'b0;
         acc_last      <= 1'b0;
         row_done      <= 1'b0;
         results_ready <= 1'b0;
      end else begin
         acc_clear     <= issue_clear;
         acc_en        <= issue_acc;
         acc_last      <= issue_last;
         row_done      <= acc_last;       // Accumulator settled
         results_ready <= compute_last;
      end
   end

   // Row number follows row_done through the pipeline
   always_ff @(posedge clk) begin
      row_d1  <= row;
      row_idx <= row_d1;
   end

endmodule

// ==== rtl/layer_top.sv ====
/*
 * Layer top
 * Fully connected 8 to 16 layer with ReLU on four parallel MAC lanes
 */
`include "layer_params.svh"

module layer_top (
   input  logic             clk,
   input  logic             reset,
   input  logic             s_valid,
   input  logic             m_ready,
   input  layer_pkg::data_t data_in,
   output logic             s_ready,
   output logic             m_valid,
   output layer_pkg::data_t data_out
);
   import layer_pkg::*;

   logic         vec_wr_en;
   logic         acc_clear;
   logic         acc_en;
   logic         row_done;
   logic         results_ready;
   logic         stream_done;
   vec_addr_t    vec_addr;
   weight_addr_t weight_addr;
   row_t         bias_addr;
   row_t         row_idx;
   data_t        lane_result [0:`LAYER_LANES-1];

   layer_sequencer u_sequencer (
      .clk           (clk),
      .reset         (reset),
      .s_valid       (s_valid),
      .stream_done   (stream_done),
      .s_ready       (s_ready),
      .vec_wr_en     (vec_wr_en),
      .acc_clear     (acc_clear),
      .acc_en        (acc_en),
      .row_done      (row_done),
      .results_ready (results_ready),
      .vec_addr      (vec_addr),
      .weight_addr   (weight_addr),
      .bias_addr     (bias_addr),
      .row_idx       (row_idx)
   );

   mac_array u_mac_array (
      .clk         (clk),
      .reset       (reset),
      .vec_wr_en   (vec_wr_en),
      .acc_clear   (acc_clear),
      .acc_en      (acc_en),
      .data_in     (data_in),
      .vec_addr    (vec_addr),
      .weight_addr (weight_addr),
      .bias_addr   (bias_addr),
      .lane_result (lane_result)
   );

   result_buffer u_result_buffer (
      .clk           (clk),
      .reset         (reset),
      .row_done      (row_done),
      .results_ready (results_ready),
      .m_ready       (m_ready),
      .row_idx       (row_idx),
      .lane_result   (lane_result),
      .m_valid       (m_valid),
      .stream_done   (stream_done),
      .data_out      (data_out)
   );

endmodule

// ==== rtl/mac_array.sv ====
/*
 * MAC array
 * Input vector memory feeding one word per cycle to all MAC lanes
 */
`include "layer_params.svh"

module mac_array (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    vec_wr_en,
   input  logic                    acc_clear,
   input  logic                    acc_en,
   input  layer_pkg::data_t        data_in,
   input  layer_pkg::vec_addr_t    vec_addr,
   input  layer_pkg::weight_addr_t weight_addr,
   input  layer_pkg::row_t         bias_addr,
   output layer_pkg::data_t        lane_result [0:`LAYER_LANES-1]
);
   import layer_pkg::*;

   data_t vec_mem [0:`LAYER_IN_LEN-1];
   data_t x_word;   // Input word shared by the lanes

   always_ff @(posedge clk) begin
      if (vec_wr_en)
         vec_mem[vec_addr] <= data_in;
      x_word <= vec_mem[vec_addr];   // Registered read
   end

   genvar lane;
   generate
      for (lane = 0; lane < `LAYER_LANES; lane++) begin : g_lane
         mac_lane #(
            .LANE(lane)
         ) u_mac_lane (
            .clk         (clk),
            .reset       (reset),
            .acc_clear   (acc_clear),
            .acc_en      (acc_en),
            .x_word      (x_word),
            .weight_addr (weight_addr),
            .bias_addr   (bias_addr),
            .acc         (lane_result[lane])
         );
      end
   endgenerate

endmodule

// ==== rtl/mac_lane.sv ====
/*
 * MAC lane
 * Reads its own weights and biases and accumulates one output row
 * with 16-bit wrapping arithmetic
 */
`include "layer_params.svh"

module mac_lane #(
   parameter int LANE = 0
) (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    acc_clear,
   input  logic                    acc_en,
   input  layer_pkg::data_t        x_word,
   input  layer_pkg::weight_addr_t weight_addr,
   input  layer_pkg::row_t         bias_addr,
   output layer_pkg::data_t        acc
);
   import layer_pkg::*;
   import layer_coef_pkg::*;

   data_t                           weight_q;
   data_t                           bias_q;
   logic signed [2*`LAYER_DATA_W-1:0] full_product;
   data_t                           product;

   // ROM reads, one cycle latency like the input memory
   always_ff @(posedge clk) begin
      weight_q <= weight_table[LANE][weight_addr];
      bias_q   <= bias_table[LANE][bias_addr];
   end

   assign full_product = weight_q * x_word;
   assign product      = full_product[`LAYER_DATA_W-1:0];   // Truncated to one word

   always_ff @(posedge clk) begin
      if (reset)
         acc <= '0;
      else if (acc_clear)
         acc <= bias_q;             // Start of a row
      else if (acc_en)
         acc <= acc + product;      // Wraps modulo 2^16
   end

endmodule

// ==== rtl/result_buffer.sv ====
/*
 * Result buffer
 * Stores the rectified lane results and streams the 16 outputs in order
 * with m_ready back-pressure
 */
`include "layer_params.svh"

module result_buffer (
   input  logic             clk,
   input  logic             reset,
   input  logic             row_done,
   input  logic             results_ready,
   input  logic             m_ready,
   input  layer_pkg::row_t  row_idx,
   input  layer_pkg::data_t lane_result [0:`LAYER_LANES-1],
   output logic             m_valid,
   output logic             stream_done,
   output layer_pkg::data_t data_out
);
   import layer_pkg::*;

   data_t    results [0:`LAYER_OUT_LEN-1];
   out_idx_t rd_ptr;      // Output being offered
   logic     out_fire;
   logic     last_word;

   // ReLU, then output row * 4 + lane
   always_ff @(posedge clk) begin
      if (row_done) begin
         for (int l = 0; l < `LAYER_LANES; l++) begin
            if (lane_result[l][`LAYER_DATA_W-1])
               results[out_idx_t'(int'(row_idx) * `LAYER_LANES + l)] <= '0;
            else
               results[out_idx_t'(int'(row_idx) * `LAYER_LANES + l)] <= lane_result[l];
         end
      end
   end

   assign out_fire    = m_valid & m_ready;
   assign last_word   = (rd_ptr == out_idx_t'(`LAYER_OUT_LEN - 1));
   assign stream_done = out_fire & last_word;
   assign data_out    = results[rd_ptr];   // Held while the pointer waits

   always_ff @(posedge clk) begin
      if (reset) begin
         m_valid <= 1'b0;
         rd_ptr  <= '0;
      end else if (results_ready) begin
         m_valid <= 1'b1;
         rd_ptr  <= '0;
      end else if (out_fire) begin
         if (last_word)
            m_valid <= 1'b0;             // All outputs delivered
         else
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile the layer testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module tb_layer -f tb.f -o tb_layer_sim > build.log 2>&1 \
   && ./obj_dir/tb_layer_sim > sim.log 2>&1 \
   || { cat build.log; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "tests failed" sim.log \
   && { echo "Simulation FAILED"; exit 1; } \
   || { echo "Simulation PASSED"; exit 0; }

// ==== tb.f ====
+incdir+include
rtl/layer_pkg.sv
rtl/layer_coef_pkg.sv
rtl/layer_sequencer.sv
rtl/mac_lane.sv
rtl/mac_array.sv
rtl/result_buffer.sv
rtl/layer_top.sv
tests/tb_layer.sv

// ==== tests/tb_layer.sv ====
/*
 * Layer testbench
 * Loads a zero vector, then random vectors back to back, and checks the
 * 16 outputs of each run against a model built from the coefficient tables
 */
`include "layer_params.svh"

module tb_layer;
   timeunit 1ns;
   timeprecision 1ps;

   import layer_pkg::*;
   import layer_coef_pkg::*;

   localparam int IN_LEN      = `LAYER_IN_LEN;
   localparam int OUT_LEN     = `LAYER_OUT_LEN;
   localparam int LANES       = `LAYER_LANES;
   localparam int NUM_RUNS    = 25;   // One zero vector, then random ones
   localparam int PATTERN_LEN = 512;
   localparam int WATCHDOG_NS = (NUM_RUNS * 200 + 1000) * 4;

   logic  clk;
   logic  reset;
   logic  s_valid;
   logic  s_ready;
   logic  m_valid;
   logic  m_ready;
   data_t data_in;
   data_t data_out;

   data_t vec [0:IN_LEN-1];
   data_t expected_q [$];
   bit    ready_pattern [0:PATTERN_LEN-1];
   int    ready_cycle = 0;
   int    errors = 0;
   int    in_words = 0;            // Words of the current vector taken
   int    out_in_run = 0;          // Outputs of the current run delivered
   int    out_total = 0;
   logic  awaiting_outputs = 1'b0; // Vector loaded, stream not finished
   logic  stall_prev;
   data_t stall_word;
   data_t exp_word;

   layer_top i_layer_top (
      .clk      (clk),
      .reset    (reset),
      .s_valid  (s_valid),
      .m_ready  (m_ready),
      .data_in  (data_in),
      .s_ready  (s_ready),
      .m_valid  (m_valid),
      .data_out (data_out)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Output j uses lane j mod 4 and row j div 4
   function automatic data_t model_output(input int j);
      int                 lane;
      int                 row;
      data_t              acc;
      logic signed [31:0] prod;
      lane = j % LANES;
      row  = j / LANES;
      acc  = bias_table[lane][row];
      for (int c = 0; c < IN_LEN; c++) begin
         prod = weight_table[lane][row * IN_LEN + c] * vec[c];
         acc  = acc + prod[`LAYER_DATA_W-1:0];   // Truncated product, wrapping sum
      end
      return acc[`LAYER_DATA_W-1] ? data_t'(0) : acc;   // ReLU
   endfunction

   task automatic queue_expected();
      for (int j = 0; j < OUT_LEN; j++)
         expected_q.push_back(model_output(j));
   endtask

   // Called on a falling edge, returns on one
   task automatic load_vector();
      int idx;
      bit fire;
      idx = 0;
      while (idx < IN_LEN) begin
         s_valid = ($urandom % 4) != 0;   // Random gaps in the input stream
         data_in = s_valid ? vec[idx] : data_t'($urandom);
         fire    = s_valid && s_ready;
         @(negedge clk);
         if (fire)
            idx++;
      end
      s_valid = 1'b0;
      data_in = '0;
   endtask

   always @(negedge clk) begin
      m_ready = ready_pattern[ready_cycle % PATTERN_LEN];
      ready_cycle++;
   end

   always @(posedge clk) begin
      if (reset) begin
         stall_prev <= 1'b0;
      end else begin
         if (s_valid && s_ready) begin
            if (in_words == IN_LEN - 1) begin
               in_words         <= 0;
               awaiting_outputs <= 1'b1;
            end else
               in_words <= in_words + 1;
         end
         assert (!(s_ready && awaiting_outputs)) else begin
            errors++;
            $display("s_ready rose again before all outputs of the run were delivered");
         end
         if (stall_prev) begin
            assert (m_valid) else begin
               errors++;
               $display("m_valid dropped before the held word was accepted");
            end
            assert (data_out == stall_word) else begin
               errors++;
               $display("Error: data_out = %h while stalled, held word %h", data_out, stall_word);
            end
         end
         stall_prev <= m_valid && !m_ready;
         stall_word <= data_out;
         if (m_valid && m_ready) begin
            assert (expected_q.size() > 0) else begin
               errors++;
               $display("Output word delivered when no word was expected");
            end
            if (expected_q.size() > 0) begin
               exp_word = expected_q.pop_front();
               assert (data_out == exp_word) else begin
                  errors++;
                  $display("Error: data_out = %h, expected %h at output %0d",
                           data_out, exp_word, out_in_run);
               end
            end
            assert (!data_out[`LAYER_DATA_W-1]) else begin
               errors++;
               $display("Error: data_out = %h has its sign bit set", data_out);
            end
            out_total <= out_total + 1;
            if (out_in_run == OUT_LEN - 1) begin
               out_in_run       <= 0;
               awaiting_outputs <= 1'b0;
            end else
               out_in_run <= out_in_run + 1;
         end
      end
   end

   assert property (@(posedge clk) reset |=> (!s_ready && !m_valid)) else begin
      errors++;
      $display("s_ready or m_valid high right after reset");
   end

   // Idle waits for s_valid
   assert property (@(posedge clk) disable iff (reset) (!s_ready && !s_valid) |=> !s_ready)
      else begin
      errors++;
      $display("s_ready rose without s_valid being applied");
   end

   assert property (@(posedge clk) disable iff (reset)
                    (s_valid && s_ready && in_words == IN_LEN - 1) |=> !s_ready) else begin
      errors++;
      $display("s_ready still high after the eighth input word");
   end

   assert property (@(posedge clk) disable iff (reset)
                    (m_valid && m_ready && out_in_run == OUT_LEN - 1) |=> !m_valid) else begin
      errors++;
      $display("m_valid still high after the sixteenth output word");
   end

   initial begin
      #WATCHDOG_NS;
      $display("Watchdog expired after %0d ns with %0d outputs delivered",
               WATCHDOG_NS, out_total);
      $display("tests failed");
      $finish;
   end

   initial begin
      int seed_val;
      clk     = 1'b0;
      reset   = 1'b1;
      s_valid = 1'b0;
      m_ready = 1'b0;
      data_in = '0;
      seed_val = $urandom(32'h3688_e5cd);
      for (int i = 0; i < PATTERN_LEN; i++)
         ready_pattern[i] = ($urandom % 3) != 0;
      repeat (16) @(negedge clk);
      reset = 1'b0;
      repeat (6) @(negedge clk);   // Idle with s_valid low
      for (int c = 0; c < IN_LEN; c++)
         vec[c] = '0;              // Outputs reduce to the rectified biases
      queue_expected();
      load_vector();
      for (int run = 1; run < NUM_RUNS; run++) begin
         for (int c = 0; c < IN_LEN; c++) begin
            if (run % 2)
               vec[c] = data_t'($urandom);
            else
               vec[c] = data_t'(int'($urandom_range(0, 511)) - 256);
         end
         queue_expected();
         load_vector();
      end
      wait (out_total == NUM_RUNS * OUT_LEN);
      repeat (4) @(negedge clk);
      $display("Summary: %0d runs, %0d outputs checked, %0d errors",
               NUM_RUNS, out_total, errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule
